//--- include/fpu_io_consts.svh
// Port addresses, size codes, stack depth and exponent biases
// for the FPU operand path

`ifndef FPU_IO_CONSTS_SVH
`define FPU_IO_CONSTS_SVH

// Data words, W0 low through W4 high
`define FPU_PORT_W0   16'hFFF8
`define FPU_PORT_W1   16'hFFFA
`define FPU_PORT_W2   16'hFFFC
`define FPU_PORT_W3   16'hFFFE
`define FPU_PORT_W4   16'hFFF0

// Control/status and command ports
`define FPU_PORT_CTRL 16'hFFF2
`define FPU_PORT_CMD  16'hFFF4

// Transfer size codes
`define FPU_SIZE_I16  3'd0
`define FPU_SIZE_F32  3'd1
`define FPU_SIZE_F64  3'd2
`define FPU_SIZE_F80  3'd3

`define FPU_STACK_DEPTH 8

// Exponent biases
`define FPU_BIAS_F32  127
`define FPU_BIAS_F64  1023
`define FPU_BIAS_F80  16383

`endif

//--- src/fpu_io_pkg.sv
// Operand union, channel payload structs and stack command type

package fpu_io_pkg;

    // Explicit integer bit in mantissa[63]
    typedef struct packed {
        logic        sign;
        logic [14:0] exponent;
        logic [63:0] mantissa;
    } fpu_ext_fields_t;

    // Same 80 bits seen as port words or as extended fields
    typedef union packed {
        logic [4:0][15:0] words;
        fpu_ext_fields_t  fields;
    } fpu_operand_t;

    typedef enum logic {
        to_fpu = 1'b0,
        to_cpu = 1'b1
    } fpu_dir_t;

    typedef enum logic {
        stack_push = 1'b0,
        stack_pop  = 1'b1
    } fpu_stack_op_t;

    // Port to converter
    typedef struct packed {
        fpu_dir_t     dir;
        logic [2:0]   size;
        fpu_operand_t data;
    } fpu_xfer_req_t;

    // Converter to stack, value in extended form
    typedef struct packed {
        fpu_stack_op_t op;
        fpu_operand_t  value;
    } fpu_stack_cmd_t;

    typedef struct packed {
        fpu_operand_t value;
        logic         error;
    } fpu_stack_rsp_t;

    // Result sits in the low bits of data
    typedef struct packed {
        fpu_operand_t data;
        logic         error;
    } fpu_xfer_rsp_t;

endpackage

//--- src/fpu_reg_stack.sv
// Eight-entry extended precision register stack
// with overflow and underflow reporting

`timescale 1ns/1ps

`include "fpu_io_consts.svh"

module fpu_reg_stack import fpu_io_pkg::*; (
    input  logic           clk,
    input  logic           reset,

    input  fpu_stack_cmd_t cmd,
    input  logic           cmd_valid,
    output logic           cmd_ready,

    output fpu_stack_rsp_t srsp,
    output logic           srsp_valid,
    input  logic           srsp_ready
);

    localparam int ptr_w = $clog2(`FPU_STACK_DEPTH);

    fpu_operand_t     mem [`FPU_STACK_DEPTH];
    logic [ptr_w:0]   count;
    logic [ptr_w-1:0] top_idx;
    logic             full;
    logic             empty;
    logic             accept;

    assign full    = (count == `FPU_STACK_DEPTH);
    assign empty   = (count == '0);
    assign top_idx = count[ptr_w-1:0] - 1'b1;

    // Hold off new commands until the response is taken
    assign cmd_ready = !srsp_valid;
    assign accept    = cmd_valid && cmd_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            count      <= '0;
            srsp_valid <= 1'b0;
        end else begin
            if (srsp_valid && srsp_ready) begin
                srsp_valid <= 1'b0;
            end
            if (accept) begin
                srsp_valid <= 1'b1;
                if (cmd.op == stack_push) begin
                    if (!full) begin
                        count <= count + 1'b1;
                    end
                end else if (!empty) begin
                    count <= count - 1'b1;
                end
            end
        end
    end

    // Array and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            srsp.value <= '0;
            srsp.error <= 1'b0;
            if (cmd.op == stack_push) begin
                if (full) begin
                    srsp.error <= 1'b1;
                end else begin
                    mem[count[ptr_w-1:0]] <= cmd.value;
                end
            end else if (empty) begin
                srsp.error <= 1'b1;
            end else begin
                srsp.value <= mem[top_idx];
            end
        end
    end

    count_bound_a: assert property (@(posedge clk) disable iff (reset)
        count <= `FPU_STACK_DEPTH);

endmodule

//--- src/fpu_format_conv.sv
// Format converter between port sizes and extended precision
// Forward stage builds stack commands, return stage narrows results

`timescale 1ns/1ps

`include "fpu_io_consts.svh"

module fpu_format_conv import fpu_io_pkg::*; (
    input  logic           clk,
    input  logic           reset,

    input  fpu_xfer_req_t  req,
    input  logic           req_valid,
    output logic           req_ready,

    output fpu_stack_cmd_t cmd,
    output logic           cmd_valid,
    input  logic           cmd_ready,

    input  fpu_stack_rsp_t srsp,
    input  logic           srsp_valid,
    output logic           srsp_ready,

    output fpu_xfer_rsp_t  rsp,
    output logic           rsp_valid,
    input  logic           rsp_ready
);

    logic       pending;
    fpu_dir_t   pend_dir;
    logic [2:0] pend_size;

    // Port size to extended, denormals flush to signed zero
    function automatic fpu_operand_t widen(input logic [2:0] size, input fpu_operand_t src);
        fpu_operand_t res;
        logic [15:0]  ival;
        logic [15:0]  mag;
        logic [31:0]  f32;
        logic [63:0]  f64;
        int           lead;
        res  = '0;
        ival = src.words[0];
        f32  = src.words[1:0];
        f64  = src.words[3:0];
        mag  = ival[15] ? -ival : ival;
        lead = 0;
        // Leading one of the magnitude
        for (int i = 0; i < 16; i++) begin
            if (mag[i]) begin
                lead = i;
            end
        end
        case (size)
            `FPU_SIZE_I16: begin
                if (ival != 16'd0) begin
                    res.fields.sign     = ival[15];
                    res.fields.exponent = 15'(`FPU_BIAS_F80 + lead);
                    res.fields.mantissa = {mag << (15 - lead), 48'd0};
                end
            end
            `FPU_SIZE_F32: begin
                res.fields.sign = f32[31];
                if (f32[30:23] == 8'hFF) begin
                    res.fields.exponent = 15'h7FFF;
                    res.fields.mantissa = {1'b1, f32[22:0], 40'd0};
                end else if (f32[30:23] != 8'd0) begin
                    res.fields.exponent = 15'(f32[30:23]) + 15'(`FPU_BIAS_F80 - `FPU_BIAS_F32);
                    res.fields.mantissa = {1'b1, f32[22:0], 40'd0};
                end
            end
            `FPU_SIZE_F64: begin
                res.fields.sign = f64[63];
                if (f64[62:52] == 11'h7FF) begin
                    res.fields.exponent = 15'h7FFF;
                    res.fields.mantissa = {1'b1, f64[51:0], 11'd0};
                end else if (f64[62:52] != 11'd0) begin
                    res.fields.exponent = 15'(f64[62:52]) + 15'(`FPU_BIAS_F80 - `FPU_BIAS_F64);
                    res.fields.mantissa = {1'b1, f64[51:0], 11'd0};
                end
            end
            default: res = src;
        endcase
        return res;
    endfunction

    // Extended to port size, truncating toward zero and saturating
    function automatic logic [79:0] narrow(input logic [2:0] size, input fpu_operand_t src);
        logic [79:0] res;
        logic        s;
        logic [14:0] e;
        logic [63:0] m;
        logic [15:0] mag;
        int          re;
        res = '0;
        s   = src.fields.sign;
        e   = src.fields.exponent;
        m   = src.fields.mantissa;
        mag = 16'd0;
        case (size)
            `FPU_SIZE_I16: begin
                re = int'(e) - `FPU_BIAS_F80;
                if (e == 15'd0 || re < 0) begin
                    res[15:0] = 16'd0;
                end else if (re >= 15) begin
                    res[15:0] = s ? 16'h8000 : 16'h7FFF;
                end else begin
                    mag       = 16'(m >> (63 - re));
                    res[15:0] = s ? -mag : mag;
                end
            end
            `FPU_SIZE_F32: begin
                re = int'(e) - `FPU_BIAS_F80 + `FPU_BIAS_F32;
                if (e == 15'h7FFF) begin
                    res[31:0] = {s, 8'hFF, m[62:40]};
                end else if (e == 15'd0 || re <= 0) begin
                    res[31:0] = {s, 31'd0};
                end else if (re >= 255) begin
                    res[31:0] = {s, 8'hFF, 23'd0};
                end else begin
                    res[31:0] = {s, re[7:0], m[62:40]};
                end
            end
            `FPU_SIZE_F64: begin
                re = int'(e) - `FPU_BIAS_F80 + `FPU_BIAS_F64;
                if (e == 15'h7FFF) begin
                    res[63:0] = {s, 11'h7FF, m[62:11]};
                end else if (e == 15'd0 || re <= 0) begin
                    res[63:0] = {s, 63'd0};
                end else if (re >= 2047) begin
                    res[63:0] = {s, 11'h7FF, 52'd0};
                end else begin
                    res[63:0] = {s, re[10:0], m[62:11]};
                end
            end
            default: res = src;
        endcase
        return res;
    endfunction

    // One transfer in flight at a time
    assign req_ready  = !cmd_valid && !pending;
    assign srsp_ready = !rsp_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending   <= 1'b0;
            cmd_valid <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            if (cmd_valid && cmd_ready) begin
                cmd_valid <= 1'b0;
            end
            if (req_valid && req_ready) begin
                pending   <= 1'b1;
                cmd_valid <= 1'b1;
            end
            if (srsp_valid && srsp_ready) begin
                rsp_valid <= 1'b1;
            end
            if (rsp_valid && rsp_ready) begin
                rsp_valid <= 1'b0;
                pending   <= 1'b0;
            end
        end
    end

    // Forward stage payload
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            pend_dir  <= req.dir;
            pend_size <= req.size;
            cmd.op    <= (req.dir == to_fpu) ? stack_push : stack_pop;
            cmd.value <= widen(req.size, req.data);
        end
    end

    // Return stage payload, a push returns no data
    always_ff @(posedge clk) begin
        if (srsp_valid && srsp_ready) begin
            rsp.error <= srsp.error;
            if (pend_dir == to_cpu) begin
                rsp.data <= narrow(pend_size, srsp.value);
            end else begin
                rsp.data <= '0;
            end
        end
    end

    // Stack answers only to a request this stage issued
    srsp_pending_a: assert property (@(posedge clk) disable iff (reset)
        srsp_valid |-> pending);

endmodule

//--- src/fpu_io_port.sv
// CPU I/O port decode, 80-bit data buffer, control/status register
// and the transfer sequencer driving the req channel

`timescale 1ns/1ps

`include "fpu_io_consts.svh"

module fpu_io_port import fpu_io_pkg::*; (
    input  logic          clk,
    input  logic          reset,

    // CPU bus
    input  logic [15:0]   io_addr,
    input  logic [15:0]   io_wdata,
    input  logic          io_access,
    input  logic          io_wr_en,
    output logic [15:0]   io_rdata,
    output logic          io_ack,

    // Request to converter
    output fpu_xfer_req_t req,
    output logic          req_valid,
    input  logic          req_ready,

    // Response from converter
    input  fpu_xfer_rsp_t rsp,
    input  logic          rsp_valid,
    output logic          rsp_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_done
    } state_t;

    state_t       state;
    fpu_operand_t buffer;
    logic [2:0]   ctrl_size;
    fpu_dir_t     ctrl_dir;
    logic         busy;
    logic         complete;
    logic         error;
    logic         hit;
    logic         wr_hit;
    logic         start;
    logic [15:0]  status;

    // Only the seven mapped addresses respond
    always_comb begin
        case (io_addr)
            `FPU_PORT_W0, `FPU_PORT_W1, `FPU_PORT_W2, `FPU_PORT_W3,
            `FPU_PORT_W4, `FPU_PORT_CTRL, `FPU_PORT_CMD: hit = 1'b1;
            default: hit = 1'b0;
        endcase
    end

    assign wr_hit = io_access && io_wr_en && hit;

    // Busy and complete follow the sequencer state
    assign busy     = (state == st_wait);
    assign complete = (state == st_done);

    // Commands while busy are acked and dropped
    assign start = wr_hit && (io_addr == `FPU_PORT_CMD) && io_wdata[0] && !busy;

    assign status = {4'b0, error, complete, busy, ctrl_dir, 5'b0, ctrl_size};

    // The port never stalls a response
    assign rsp_ready = 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            io_ack    <= 1'b0;
            buffer    <= '0;
            ctrl_size <= 3'd0;
            ctrl_dir  <= to_fpu;
            error     <= 1'b0;
            req_valid <= 1'b0;
            state     <= st_idle;
        end else begin
            io_ack <= io_access && hit;

            if (wr_hit) begin
                case (io_addr)
                    `FPU_PORT_W0: buffer.words[0] <= io_wdata;
                    `FPU_PORT_W1: buffer.words[1] <= io_wdata;
                    `FPU_PORT_W2: buffer.words[2] <= io_wdata;
                    `FPU_PORT_W3: buffer.words[3] <= io_wdata;
                    `FPU_PORT_W4: buffer.words[4] <= io_wdata;
                    `FPU_PORT_CTRL: begin
                        ctrl_size <= io_wdata[2:0];
                        ctrl_dir  <= fpu_dir_t'(io_wdata[8]);
                    end
                    default: ;
                endcase
            end

            if (req_valid && req_ready) begin
                req_valid <= 1'b0;
            end

            case (state)
                st_idle, st_done: begin
                    if (start) begin
                        req_valid <= 1'b1;
                        error     <= 1'b0;
                        state     <= st_wait;
                    end
                end
                st_wait: begin
                    if (rsp_valid) begin
                        error <= rsp.error;
                        state <= st_done;
                        // A result load wins over a CPU write in the same cycle
                        if (req.dir == to_cpu && !rsp.error) begin
                            buffer <= rsp.data;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Request payload is captured at command start
    always_ff @(posedge clk) begin
        if (start) begin
            req.dir  <= ctrl_dir;
            req.size <= ctrl_size;
            req.data <= buffer;
        end
    end

    // Read data for the ack cycle
    always_ff @(posedge clk) begin
        case (io_addr)
            `FPU_PORT_W0:   io_rdata <= buffer.words[0];
            `FPU_PORT_W1:   io_rdata <= buffer.words[1];
            `FPU_PORT_W2:   io_rdata <= buffer.words[2];
            `FPU_PORT_W3:   io_rdata <= buffer.words[3];
            `FPU_PORT_W4:   io_rdata <= buffer.words[4];
            `FPU_PORT_CTRL: io_rdata <= status;
            default:        io_rdata <= 16'h0000;
        endcase
    end

    // Request held steady until the converter takes it
    req_stable_a: assert property (@(posedge clk) disable iff (reset)
        req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

//--- src/fpu_io_top.sv
// Operand path top level: port, converter and register stack

`timescale 1ns/1ps

module fpu_io_top import fpu_io_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] io_addr,
    input  logic [15:0] io_wdata,
    input  logic        io_wr_en,
    input  logic        io_access,
    output logic [15:0] io_rdata,
    output logic        io_ack
);

    fpu_xfer_req_t  req;
    logic           req_valid;
    logic           req_ready;
    fpu_stack_cmd_t cmd;
    logic           cmd_valid;
    logic           cmd_ready;
    fpu_stack_rsp_t srsp;
    logic           srsp_valid;
    logic           srsp_ready;
    fpu_xfer_rsp_t  rsp;
    logic           rsp_valid;
    logic           rsp_ready;

    fpu_io_port u_port (
        .clk       (clk),
        .reset     (reset),
        .io_addr   (io_addr),
        .io_wdata  (io_wdata),
        .io_access (io_access),
        .io_wr_en  (io_wr_en),
        .io_rdata  (io_rdata),
        .io_ack    (io_ack),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    fpu_format_conv u_conv (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .srsp       (srsp),
        .srsp_valid (srsp_valid),
        .srsp_ready (srsp_ready),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready)
    );

    fpu_reg_stack u_stack (
        .clk        (clk),
        .reset      (reset),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .srsp       (srsp),
        .srsp_valid (srsp_valid),
        .srsp_ready (srsp_ready)
    );

endmodule

//--- tests/fpu_io_tb.sv
// Directed testbench for the FPU operand path
// Bus tasks, reference conversions, compare tasks and one task per test

`timescale 1ns/1ps

`include "fpu_io_consts.svh"

module fpu_io_tb import fpu_io_pkg::*; ();

    localparam int num_tests       = 6;
    localparam int per_test_cycles = 800;
    localparam int watchdog_cycles = num_tests * per_test_cycles + 200;
    localparam int ack_limit       = 8;
    localparam int poll_limit      = 50;

    logic        clk;
    logic        reset;
    logic [15:0] io_addr;
    logic [15:0] io_wdata;
    logic        io_wr_en;
    logic        io_access;
    logic [15:0] io_rdata;
    logic        io_ack;

    int          checks;
    int          errors;

    fpu_io_top DUT (
        .clk       (clk),
        .reset     (reset),
        .io_addr   (io_addr),
        .io_wdata  (io_wdata),
        .io_wr_en  (io_wr_en),
        .io_access (io_access),
        .io_rdata  (io_rdata),
        .io_ack    (io_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reference models
    function automatic fpu_operand_t ext_from_int(input logic [15:0] v);
        fpu_operand_t r;
        logic [15:0]  mag;
        int           shifts;
        r = '0;
        if (v != 16'd0) begin
            mag    = v[15] ? (~v + 16'd1) : v;
            shifts = 0;
            // Normalize until the integer bit is set
            while (!mag[15]) begin
                mag = mag << 1;
                shifts++;
            end
            r.fields.sign     = v[15];
            r.fields.exponent = 15'(`FPU_BIAS_F80 + 15 - shifts);
            r.fields.mantissa = {mag, 48'd0};
        end
        return r;
    endfunction

    // Normal extended value near exponent zero
    function automatic fpu_operand_t rand_ext();
        fpu_operand_t r;
        r.fields.sign     = 1'($urandom);
        r.fields.exponent = 15'(`FPU_BIAS_F80 - 32 + ($urandom % 64));
        r.fields.mantissa = {1'b1, 31'($urandom), 32'($urandom)};
        return r;
    endfunction

    function automatic logic [15:0] word_addr(input int i);
        case (i)
            0:       return `FPU_PORT_W0;
            1:       return `FPU_PORT_W1;
            2:       return `FPU_PORT_W2;
            3:       return `FPU_PORT_W3;
            default: return `FPU_PORT_W4;
        endcase
    endfunction

    function automatic logic [15:0] ctrl_word(input fpu_dir_t dir, input logic [2:0] size);
        return {7'b0, dir, 5'b0, size};
    endfunction

    // Compare tasks
    task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED time %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_operand(input fpu_operand_t got, input fpu_operand_t exp,
                                 input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED time %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Complete is bit 10 and error is bit 11
    task automatic check_status(input logic [15:0] st, input logic exp_complete,
                                input logic exp_error, input string what);
        checks++;
        if (st[10] !== exp_complete || st[11] !== exp_error) begin
            errors++;
            $display("CHECK FAILED time %0t: %s, complete %b error %b expected %b %b",
                     $time, what, st[10], st[11], exp_complete, exp_error);
        end
    endtask

    // Bus tasks
    task automatic wait_ack(input logic [15:0] addr);
        int n;
        n = 0;
        while (!io_ack && n < ack_limit) begin
            @(posedge clk);
            #10;
            n++;
        end
        if (!io_ack) begin
            errors++;
            $display("Access to address %h was never acknowledged", addr);
        end
    endtask

    task automatic io_write(input logic [15:0] addr, input logic [15:0] data);
        @(posedge clk);
        #10;
        io_addr   = addr;
        io_wdata  = data;
        io_wr_en  = 1'b1;
        io_access = 1'b1;
        @(posedge clk);
        #10;
        io_access = 1'b0;
        io_wr_en  = 1'b0;
        wait_ack(addr);
    endtask

    task automatic io_read(input logic [15:0] addr, output logic [15:0] data);
        @(posedge clk);
        #10;
        io_addr   = addr;
        io_wr_en  = 1'b0;
        io_access = 1'b1;
        @(posedge clk);
        #10;
        io_access = 1'b0;
        wait_ack(addr);
        data = io_rdata;
    endtask

    // io_ack must stay low for an unmapped address
    task automatic check_no_ack(input logic [15:0] addr, input logic wr);
        logic seen;
        seen = 1'b0;
        @(posedge clk);
        #10;
        io_addr   = addr;
        io_wdata  = 16'hFFFF;
        io_wr_en  = wr;
        io_access = 1'b1;
        @(posedge clk);
        #10;
        io_access = 1'b0;
        io_wr_en  = 1'b0;
        repeat (3) begin
            if (io_ack) begin
                seen = 1'b1;
            end
            @(posedge clk);
            #10;
        end
        checks++;
        if (seen) begin
            errors++;
            $display("Unmapped address %h was acknowledged", addr);
        end
    endtask

    task automatic write_operand(input fpu_operand_t op);
        for (int i = 0; i < 5; i++) begin
            io_write(word_addr(i), op.words[i]);
        end
    endtask

    task automatic read_operand(output fpu_operand_t op);
        logic [15:0] w;
        for (int i = 0; i < 5; i++) begin
            io_read(word_addr(i), w);
            op.words[i] = w;
        end
    endtask

    task automatic wait_complete(output logic [15:0] st);
        int polls;
        polls = 0;
        st    = 16'h0000;
        while (!st[10] && polls < poll_limit) begin
            io_read(`FPU_PORT_CTRL, st);
            polls++;
        end
        if (!st[10]) begin
            errors++;
            $display("Transfer did not complete within %0d status polls", poll_limit);
        end
    endtask

    task automatic run_xfer(input fpu_dir_t dir, input logic [2:0] size,
                            output logic [15:0] st);
        io_write(`FPU_PORT_CTRL, ctrl_word(dir, size));
        io_write(`FPU_PORT_CMD, 16'h0001);
        wait_complete(st);
    endtask

    // Tests
    task automatic test_reset_values();
        fpu_operand_t op;
        logic [15:0]  st;
        read_operand(op);
        check_operand(op, '0, "data buffer after reset");
        io_read(`FPU_PORT_CTRL, st);
        check_word(st, 16'h0000, "control/status after reset");
        check_no_ack(16'h1234, 1'b0);
        check_no_ack(16'hFFF6, 1'b1);
    endtask

    task automatic test_buffer_rw();
        fpu_operand_t wr;
        fpu_operand_t rd;
        logic [15:0]  st;
        for (int i = 0; i < 5; i++) begin
            wr.words[i] = 16'($urandom);
        end
        write_operand(wr);
        read_operand(rd);
        check_operand(rd, wr, "data words readback");
        io_write(`FPU_PORT_CTRL, ctrl_word(to_cpu, `FPU_SIZE_F64));
        io_read(`FPU_PORT_CTRL, st);
        check_word(st, 16'h0102, "control register readback");
    endtask

    task automatic test_int16_path();
        logic [15:0]  v;
        fpu_operand_t op;
        fpu_operand_t exp;
        fpu_operand_t got;
        logic [15:0]  st;
        for (int k = 0; k < 2; k++) begin
            v = (k == 0) ? 16'($urandom) : 16'h8000;
            op          = '0;
            op.words[0] = v;
            write_operand(op);
            run_xfer(to_fpu, `FPU_SIZE_I16, st);
            check_status(st, 1'b1, 1'b0, "int16 push");
            run_xfer(to_cpu, `FPU_SIZE_F80, st);
            check_status(st, 1'b1, 1'b0, "extended pop");
            read_operand(got);
            check_operand(got, ext_from_int(v), $sformatf("int16 %h widened", v));
            // Same integer back through the int16 narrowing
            write_operand(op);
            run_xfer(to_fpu, `FPU_SIZE_I16, st);
            run_xfer(to_cpu, `FPU_SIZE_I16, st);
            check_status(st, 1'b1, 1'b0, "int16 pop");
            exp          = '0;
            exp.words[0] = v;
            read_operand(got);
            check_operand(got, exp, "int16 round trip");
        end
    endtask

    task automatic test_float_paths();
        logic [31:0]  f;
        logic [63:0]  d;
        fpu_operand_t op;
        fpu_operand_t exp;
        fpu_operand_t got;
        logic [15:0]  st;
        f  = {1'($urandom), 8'(1 + $urandom % 254), 23'($urandom)};
        d  = {f[31], 11'(int'(f[30:23]) - `FPU_BIAS_F32 + `FPU_BIAS_F64), f[22:0], 29'd0};
        op = '0;
        op.words[1:0] = f;
        write_operand(op);
        run_xfer(to_fpu, `FPU_SIZE_F32, st);
        run_xfer(to_cpu, `FPU_SIZE_F64, st);
        check_status(st, 1'b1, 1'b0, "single to double");
        exp = '0;
        exp.words[3:0] = d;
        read_operand(got);
        check_operand(got, exp, "single rebiased as double");

        // Exponent overflow on narrowing to single
        op = rand_ext();
        op.fields.exponent = 15'(`FPU_BIAS_F80 + 200);
        write_operand(op);
        run_xfer(to_fpu, `FPU_SIZE_F80, st);
        run_xfer(to_cpu, `FPU_SIZE_F32, st);
        exp = '0;
        exp.words[1:0] = {op.fields.sign, 8'hFF, 23'd0};
        read_operand(got);
        check_operand(got, exp, "overflow to single infinity");

        // Magnitude above the int16 range with either sign
        for (int s = 0; s < 2; s++) begin
            op = rand_ext();
            op.fields.sign     = 1'(s);
            op.fields.exponent = 15'(`FPU_BIAS_F80 + 20);
            write_operand(op);
            run_xfer(to_fpu, `FPU_SIZE_F80, st);
            run_xfer(to_cpu, `FPU_SIZE_I16, st);
            exp = '0;
            exp.words[0] = (s == 0) ? 16'h7FFF : 16'h8000;
            read_operand(got);
            check_operand(got, exp, "int16 saturation");
        end
    endtask

    task automatic test_stack_limits();
        fpu_operand_t vals [8];
        fpu_operand_t extra;
        fpu_operand_t got;
        logic [15:0]  st;
        for (int i = 0; i < 8; i++) begin
            vals[i] = rand_ext();
            write_operand(vals[i]);
            run_xfer(to_fpu, `FPU_SIZE_F80, st);
            check_status(st, 1'b1, 1'b0, $sformatf("push %0d", i));
        end
        extra = rand_ext();
        write_operand(extra);
        run_xfer(to_fpu, `FPU_SIZE_F80, st);
        check_status(st, 1'b1, 1'b1, "push on full stack");
        read_operand(got);
        check_operand(got, extra, "buffer after overflow");
        // LIFO order
        for (int i = 7; i >= 0; i--) begin
            run_xfer(to_cpu, `FPU_SIZE_F80, st);
            check_status(st, 1'b1, 1'b0, $sformatf("pop %0d", i));
            read_operand(got);
            check_operand(got, vals[i], $sformatf("popped entry %0d", i));
        end
        run_xfer(to_cpu, `FPU_SIZE_F80, st);
        check_status(st, 1'b1, 1'b1, "pop on empty stack");
        read_operand(got);
        check_operand(got, vals[0], "buffer after underflow");
    endtask

    task automatic test_cmd_while_busy();
        fpu_operand_t a;
        fpu_operand_t b;
        fpu_operand_t got;
        logic [15:0]  st;
        a = rand_ext();
        b = rand_ext();
        write_operand(a);
        run_xfer(to_fpu, `FPU_SIZE_F80, st);
        write_operand(b);
        run_xfer(to_fpu, `FPU_SIZE_F80, st);
        io_write(`FPU_PORT_CTRL, ctrl_word(to_cpu, `FPU_SIZE_F80));
        io_write(`FPU_PORT_CMD, 16'h0001);
        // Lands while the first pop is in flight
        io_write(`FPU_PORT_CMD, 16'h0001);
        wait_complete(st);
        check_status(st, 1'b1, 1'b0, "pop with second command");
        read_operand(got);
        check_operand(got, b, "single result after command while busy");
        // Entry a is still there only if the second command was dropped
        run_xfer(to_cpu, `FPU_SIZE_F80, st);
        check_status(st, 1'b1, 1'b0, "pop of remaining entry");
        read_operand(got);
        check_operand(got, a, "remaining entry");
    endtask

    initial begin
        checks    = 0;
        errors    = 0;
        void'($urandom(32'hdd864027));
        reset     = 1'b1;
        io_addr   = 16'h0000;
        io_wdata  = 16'h0000;
        io_wr_en  = 1'b0;
        io_access = 1'b0;
        repeat (16) @(posedge clk);
        #10;
        reset = 1'b0;

        test_reset_values();
        test_buffer_rw();
        test_int16_path();
        test_float_paths();
        test_stack_limits();
        test_cmd_while_busy();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Simulation stopped after %0d cycles without finishing the tests",
                 watchdog_cycles);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- fpu_io_top.f
+incdir+include
src/fpu_io_pkg.sv
src/fpu_reg_stack.sv
src/fpu_format_conv.sv
src/fpu_io_port.sv
src/fpu_io_top.sv
tests/fpu_io_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the FPU operand path testbench with Verilator, run it and scan the log

set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f fpu_io_top.f \
    --top-module fpu_io_tb \
    -Mdir obj_dir

./obj_dir/Vfpu_io_tb > sim.log 2>&1

cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
